// File: source/buffer_cfg_pkg.sv
`default_nettype none

package buffer_cfg_pkg;

  // one bank per channel
  localparam int N_BANKS = 2;

  // words per bank
  localparam int BANK_DEPTH = 64;

  localparam int ADDR_WIDTH = $clog2(BANK_DEPTH);

  // wide enough for a full single channel capture of N_BANKS * BANK_DEPTH
  localparam int COUNT_WIDTH = ADDR_WIDTH + 2;

  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    CAPTURING,
    DONE
  } capture_state_e;

  // layout of the two banks
  typedef enum logic {
    DUAL_BANK,
    SINGLE_CHANNEL
  } banking_mode_e;

  // single-cycle strobes from the processor
  typedef struct packed {
    logic arm;
    logic start;
    logic stop;
    logic capture_reset;
  } capture_cmd_t;

endpackage

`default_nettype wire

// File: source/sample_data_pkg.sv
`default_nettype none

package sample_data_pkg;

  localparam int SAMPLE_WIDTH = 16;

  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  // both converter channels captured on one valid strobe
  typedef struct packed {
    sample_t ch1;
    sample_t ch0;
  } sample_pair_t;

  // one word on the readout stream
  typedef struct packed {
    sample_t sample;
    logic    bank;
    logic    last;
  } readout_beat_t;

endpackage

`default_nettype wire

// File: source/capture_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module capture_fsm (
  input  logic                           ps_clk,
  input  logic                           rst_i,
  input  buffer_cfg_pkg::capture_cmd_t   cmd_i,
  input  logic                           trigger_i,
  input  logic                           full_i,
  output buffer_cfg_pkg::capture_state_e state_o,
  output logic                           capturing_o,
  output logic                           clear_o
);

  import buffer_cfg_pkg::*;

  capture_state_e state_q;
  capture_state_e state_d;
  logic           begin_capture;

  always_comb begin
    state_d       = state_q;
    begin_capture = 1'b0;
    // capture reset wins over everything
    if (cmd_i.capture_reset) begin
      state_d = IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (!cmd_i.stop) begin
            if (cmd_i.start) begin
              state_d       = CAPTURING;
              begin_capture = 1'b1;
            end else if (cmd_i.arm) begin
              state_d = ARMED;
            end
          end
        end
        ARMED: begin
          if (cmd_i.stop) begin
            state_d = IDLE;
          end else if (cmd_i.start || trigger_i) begin
            // software start or hardware trigger
            state_d       = CAPTURING;
            begin_capture = 1'b1;
          end
        end
        CAPTURING: begin
          // full_i is high on the edge that stores the last word
          if (full_i || cmd_i.stop) begin
            state_d = DONE;
          end
        end
        DONE: begin
          // held until a capture reset
          state_d = DONE;
        end
        default: begin
          state_d = IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge ps_clk) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o     = state_q;
  assign capturing_o = (state_q == CAPTURING);
  // count restarts with every new capture
  assign clear_o     = cmd_i.capture_reset | begin_capture;

endmodule

`default_nettype wire

// File: source/write_addr_counter.sv
`default_nettype none
`timescale 1ns/10ps

module write_addr_counter (
  input  logic                                     ps_clk,
  input  logic                                     rst_i,
  input  logic                                     clear_i,
  input  logic                                     write_i,
  input  buffer_cfg_pkg::banking_mode_e            mode_i,
  output logic [buffer_cfg_pkg::ADDR_WIDTH-1:0]    addr_o,
  output logic                                     bank_sel_o,
  output logic                                     full_o,
  output logic [buffer_cfg_pkg::COUNT_WIDTH-1:0]   count_o
);

  import buffer_cfg_pkg::*;

  localparam logic [COUNT_WIDTH-1:0] DUAL_LAST   = COUNT_WIDTH'(BANK_DEPTH - 1);
  localparam logic [COUNT_WIDTH-1:0] SINGLE_LAST = COUNT_WIDTH'(N_BANKS * BANK_DEPTH - 1);

  logic [COUNT_WIDTH-1:0] count_q;
  logic [COUNT_WIDTH-1:0] last_count;

  // number of stored beats
  always_ff @(posedge ps_clk) begin
    if (rst_i || clear_i) begin
      count_q <= '0;
    end else if (write_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  // single channel runs through both banks
  assign last_count = (mode_i == SINGLE_CHANNEL) ? SINGLE_LAST : DUAL_LAST;

  assign addr_o = count_q[ADDR_WIDTH-1:0];

  // top address bit picks the bank when channel 0 spans both
  assign bank_sel_o = (mode_i == SINGLE_CHANNEL) ? count_q[ADDR_WIDTH] : 1'b0;

  // high while the write that fills the buffer is presented
  assign full_o = write_i && (count_q == last_count);

  assign count_o = count_q;

endmodule

`default_nettype wire

// File: source/sample_bank.sv
`default_nettype none
`timescale 1ns/10ps

module sample_bank (
  input  logic                                  ps_clk,
  input  logic                                  we_i,
  input  logic [buffer_cfg_pkg::ADDR_WIDTH-1:0] waddr_i,
  input  sample_data_pkg::sample_t              wdata_i,
  input  logic [buffer_cfg_pkg::ADDR_WIDTH-1:0] raddr_i,
  output sample_data_pkg::sample_t              rdata_o
);

  import buffer_cfg_pkg::*;
  import sample_data_pkg::*;

  sample_t mem [BANK_DEPTH];
  sample_t rdata_q;

  always_ff @(posedge ps_clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read with one cycle latency
  always_ff @(posedge ps_clk) begin
    rdata_q <= mem[raddr_i];
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: source/readout_sequencer.sv
`default_nettype none
`timescale 1ns/10ps

module readout_sequencer (
  input  logic                                   ps_clk,
  input  logic                                   rst_i,
  input  logic                                   start_i,
  input  logic                                   abort_i,
  input  logic                                   enable_i,
  input  logic [buffer_cfg_pkg::COUNT_WIDTH-1:0] count_i,
  input  buffer_cfg_pkg::banking_mode_e          mode_i,
  output logic [buffer_cfg_pkg::ADDR_WIDTH-1:0]  raddr_o,
  output logic                                   rbank_o,
  input  logic [buffer_cfg_pkg::N_BANKS-1:0][sample_data_pkg::SAMPLE_WIDTH-1:0] rdata_i,
  output sample_data_pkg::readout_beat_t         beat_o,
  output logic                                   beat_valid_o,
  input  logic                                   beat_ready_i
);

  import buffer_cfg_pkg::*;
  import sample_data_pkg::*;

  logic [COUNT_WIDTH-1:0] ptr_q;
  logic [COUNT_WIDTH-1:0] total;
  logic [COUNT_WIDTH-1:0] last_ptr;
  logic [COUNT_WIDTH-1:0] rd_off;
  logic                   rd_bank;
  logic                   active_q;
  logic                   issue;
  logic                   inflight_q;
  logic                   bank_d;
  logic                   last_d;
  logic                   skid_valid_q;
  readout_beat_t          skid_q;
  readout_beat_t          live_beat;

  // beat index to bank and address
  always_comb begin
    if (mode_i == SINGLE_CHANNEL) begin
      total   = count_i;
      rd_bank = ptr_q[ADDR_WIDTH];
      rd_off  = ptr_q;
    end else begin
      total   = {count_i[COUNT_WIDTH-2:0], 1'b0};
      rd_bank = (ptr_q >= count_i);
      rd_off  = rd_bank ? ptr_q - count_i : ptr_q;
    end
  end

  assign last_ptr = total - 1'b1;
  assign raddr_o  = rd_off[ADDR_WIDTH-1:0];
  assign rbank_o  = rd_bank;

  // at most one word is held between the skid and the bank output
  assign issue = active_q && (!beat_valid_o || beat_ready_i);

  always_ff @(posedge ps_clk) begin
    if (rst_i || abort_i || !enable_i) begin
      active_q     <= 1'b0;
      inflight_q   <= 1'b0;
      skid_valid_q <= 1'b0;
      ptr_q        <= '0;
    end else if (start_i && (total != '0)) begin
      active_q     <= 1'b1;
      inflight_q   <= 1'b0;
      skid_valid_q <= 1'b0;
      ptr_q        <= '0;
    end else begin
      inflight_q <= issue;
      if (issue) begin
        ptr_q <= ptr_q + 1'b1;
        if (ptr_q == last_ptr) begin
          active_q <= 1'b0;
        end
      end
      if (inflight_q && !beat_ready_i) begin
        skid_valid_q <= 1'b1;
      end else if (skid_valid_q && beat_ready_i) begin
        skid_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge ps_clk) begin
    if (issue) begin
      bank_d <= rd_bank;
      last_d <= (ptr_q == last_ptr);
    end
    // catch the bank output before it moves on
    if (inflight_q && !beat_ready_i) begin
      skid_q <= live_beat;
    end
  end

  assign live_beat.sample = rdata_i[bank_d];
  assign live_beat.bank   = bank_d;
  assign live_beat.last   = last_d;

  assign beat_o       = skid_valid_q ? skid_q : live_beat;
  assign beat_valid_o = skid_valid_q | inflight_q;

endmodule

`default_nettype wire

// File: source/timetag_buffer.sv
`default_nettype none
`timescale 1ns/10ps

module timetag_buffer (
  input  logic                                   ps_clk,
  input  logic                                   rst_i,
  input  buffer_cfg_pkg::capture_cmd_t           cmd_i,
  input  logic                                   trigger_i,
  input  buffer_cfg_pkg::banking_mode_e          mode_i,
  input  sample_data_pkg::sample_pair_t          samples_i,
  input  logic                                   sample_valid_i,
  input  logic                                   readout_start_i,
  input  logic                                   readout_reset_i,
  output sample_data_pkg::readout_beat_t         beat_o,
  output logic                                   beat_valid_o,
  input  logic                                   beat_ready_i,
  output buffer_cfg_pkg::capture_state_e         state_o,
  output logic [buffer_cfg_pkg::COUNT_WIDTH-1:0] write_count_o
);

  import buffer_cfg_pkg::*;
  import sample_data_pkg::*;

  capture_state_e                        state;
  logic                                  capturing;
  logic                                  clear;
  logic                                  full;
  logic                                  write_en;
  logic [ADDR_WIDTH-1:0]                 waddr;
  logic                                  wr_bank;
  logic [COUNT_WIDTH-1:0]                count;
  logic [N_BANKS-1:0]                    bank_we;
  sample_t                               bank_wdata [N_BANKS];
  logic [ADDR_WIDTH-1:0]                 bank_raddr [N_BANKS];
  logic [ADDR_WIDTH-1:0]                 raddr;
  logic                                  rbank;
  logic [N_BANKS-1:0][SAMPLE_WIDTH-1:0]  bank_rdata;

  capture_fsm i_capture_fsm (
    .ps_clk      (ps_clk),
    .rst_i       (rst_i),
    .cmd_i       (cmd_i),
    .trigger_i   (trigger_i),
    .full_i      (full),
    .state_o     (state),
    .capturing_o (capturing),
    .clear_o     (clear)
  );

  assign write_en = capturing & sample_valid_i;

  write_addr_counter i_write_addr_counter (
    .ps_clk     (ps_clk),
    .rst_i      (rst_i),
    .clear_i    (clear),
    .write_i    (write_en),
    .mode_i     (mode_i),
    .addr_o     (waddr),
    .bank_sel_o (wr_bank),
    .full_o     (full),
    .count_o    (count)
  );

  // layout by mode
  always_comb begin
    if (mode_i == SINGLE_CHANNEL) begin
      bank_we[0]    = write_en & ~wr_bank;
      bank_we[1]    = write_en & wr_bank;
      bank_wdata[0] = samples_i.ch0;
      bank_wdata[1] = samples_i.ch0;
    end else begin
      bank_we[0]    = write_en;
      bank_we[1]    = write_en;
      bank_wdata[0] = samples_i.ch0;
      bank_wdata[1] = samples_i.ch1;
    end
  end

  for (genvar i = 0; i < N_BANKS; i++) begin : g_bank
    // idle bank parks at address 0
    assign bank_raddr[i] = (rbank == 1'(i)) ? raddr : '0;

    sample_bank i_sample_bank (
      .ps_clk  (ps_clk),
      .we_i    (bank_we[i]),
      .waddr_i (waddr),
      .wdata_i (bank_wdata[i]),
      .raddr_i (bank_raddr[i]),
      .rdata_o (bank_rdata[i])
    );
  end

  readout_sequencer i_readout_sequencer (
    .ps_clk       (ps_clk),
    .rst_i        (rst_i),
    .start_i      (readout_start_i),
    .abort_i      (readout_reset_i),
    .enable_i     (state == DONE),
    .count_i      (count),
    .mode_i       (mode_i),
    .raddr_o      (raddr),
    .rbank_o      (rbank),
    .rdata_i      (bank_rdata),
    .beat_o       (beat_o),
    .beat_valid_o (beat_valid_o),
    .beat_ready_i (beat_ready_i)
  );

  assign state_o       = state;
  assign write_count_o = count;

endmodule

`default_nettype wire

// File: tb/timetag_buffer_properties.sv
`default_nettype none
`timescale 1ns/10ps

module timetag_buffer_properties (
  input logic                           ps_clk,
  input logic                           rst_i,
  input logic                           full_i,
  input buffer_cfg_pkg::capture_state_e state_i,
  input sample_data_pkg::readout_beat_t beat_i,
  input logic                           beat_valid_i,
  input logic                           beat_ready_i
);

  import buffer_cfg_pkg::*;
  import sample_data_pkg::*;

  int unsigned failure_count = 0;

  // stalled beat holds until taken or aborted
  beat_held: assert property (@(posedge ps_clk) disable iff (rst_i)
    (beat_valid_i && !beat_ready_i) |=> (!beat_valid_i || $stable(beat_i)))
    else begin
      $error("beat changed while stalled");
      failure_count++;
    end

  stop_when_full: assert property (@(posedge ps_clk) disable iff (rst_i)
    full_i |=> (state_i != CAPTURING))
    else begin
      $error("still capturing after the buffer filled");
      failure_count++;
    end

  quiet_after_reset: assert property (@(posedge ps_clk) rst_i |=> !beat_valid_i)
    else begin
      $error("beat valid in the cycle after reset");
      failure_count++;
    end

endmodule

bind timetag_buffer timetag_buffer_properties i_timetag_buffer_properties (
  .ps_clk       (ps_clk),
  .rst_i        (rst_i),
  .full_i       (full),
  .state_i      (state),
  .beat_i       (beat_o),
  .beat_valid_i (beat_valid_o),
  .beat_ready_i (beat_ready_i)
);

`default_nettype wire

// File: tb/timetag_buffer_tb.sv
`default_nettype none
`timescale 1ns/10ps

module timetag_buffer_tb;

  import buffer_cfg_pkg::*;
  import sample_data_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int TEST_COUNT = 6;
  // worst readout is every beat stalled for a while
  localparam int READ_LIMIT = 4 * N_BANKS * BANK_DEPTH + 16;
  localparam int CAPTURE_LIMIT = N_BANKS * BANK_DEPTH + 40;
  localparam int WATCHDOG_CYCLES = 2 * (16 + TEST_COUNT * (CAPTURE_LIMIT + 2 * READ_LIMIT));

  logic                   ps_clk;
  logic                   rst_i;
  capture_cmd_t           cmd_i;
  logic                   trigger_i;
  banking_mode_e          mode_i;
  sample_pair_t           samples_i;
  logic                   sample_valid_i;
  logic                   readout_start_i;
  logic                   readout_reset_i;
  readout_beat_t          beat_o;
  logic                   beat_valid_o;
  logic                   beat_ready_i;
  capture_state_e         state_o;
  logic [COUNT_WIDTH-1:0] write_count_o;

  // reference model
  sample_pair_t  stored[$];
  readout_beat_t expected[$];
  banking_mode_e model_mode;

  logic [31:0] lfsr_q = 32'h6215;
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;

  timetag_buffer i_timetag_buffer (
    .ps_clk          (ps_clk),
    .rst_i           (rst_i),
    .cmd_i           (cmd_i),
    .trigger_i       (trigger_i),
    .mode_i          (mode_i),
    .samples_i       (samples_i),
    .sample_valid_i  (sample_valid_i),
    .readout_start_i (readout_start_i),
    .readout_reset_i (readout_reset_i),
    .beat_o          (beat_o),
    .beat_valid_o    (beat_valid_o),
    .beat_ready_i    (beat_ready_i),
    .state_o         (state_o),
    .write_count_o   (write_count_o)
  );

  initial begin
    ps_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ps_clk = ~ps_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic log_failure(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic model_write(input sample_pair_t p);
    int capacity;
    capacity = (model_mode == SINGLE_CHANNEL) ? N_BANKS * BANK_DEPTH : BANK_DEPTH;
    if (stored.size() < capacity) begin
      stored.push_back(p);
    end
  endtask

  // dual bank reads bank 0 then bank 1 while single channel keeps write order
  task automatic build_expected();
    readout_beat_t b;
    expected.delete();
    for (int i = 0; i < stored.size(); i++) begin
      b.sample = stored[i].ch0;
      b.bank   = (model_mode == SINGLE_CHANNEL) ? (i >= BANK_DEPTH) : 1'b0;
      b.last   = 1'b0;
      expected.push_back(b);
    end
    if (model_mode == DUAL_BANK) begin
      for (int i = 0; i < stored.size(); i++) begin
        b.sample = stored[i].ch1;
        b.bank   = 1'b1;
        b.last   = 1'b0;
        expected.push_back(b);
      end
    end
    if (expected.size() > 0) begin
      b = expected.pop_back();
      b.last = 1'b1;
      expected.push_back(b);
    end
  endtask

  task automatic pulse_cmd(input bit do_arm, input bit do_start, input bit do_stop,
                           input bit do_reset);
    @(negedge ps_clk);
    cmd_i.arm           = do_arm;
    cmd_i.start         = do_start;
    cmd_i.stop          = do_stop;
    cmd_i.capture_reset = do_reset;
    @(negedge ps_clk);
    cmd_i = '0;
  endtask

  task automatic pulse_trigger();
    @(negedge ps_clk);
    trigger_i = 1'b1;
    @(negedge ps_clk);
    trigger_i = 1'b0;
  endtask

  task automatic reset_capture(input banking_mode_e m);
    pulse_cmd(1'b0, 1'b0, 1'b0, 1'b1);
    mode_i     = m;
    model_mode = m;
    stored.delete();
  endtask

  task automatic send_samples(input int n, input bit keep);
    sample_pair_t p;
    for (int i = 0; i < n; i++) begin
      @(negedge ps_clk);
      p = rand_bits(32);
      samples_i      = p;
      sample_valid_i = 1'b1;
      if (keep) begin
        model_write(p);
      end
    end
    @(negedge ps_clk);
    sample_valid_i = 1'b0;
  endtask

  task automatic check_status(input capture_state_e s, input int count, input string where);
    if (state_o !== s) begin
      log_failure($sformatf("%s: state %s, expected %s", where, state_o.name(), s.name()));
    end
    if (write_count_o !== COUNT_WIDTH'(count)) begin
      log_failure($sformatf("%s: write count %0d, expected %0d", where, write_count_o, count));
    end
  endtask

  // abort_after of zero reads the whole buffer
  task automatic read_stream(input int abort_after, input bit stall);
    int          idx;
    int          cycles;
    bit          finished;
    logic [31:0] r;
    idx      = 0;
    cycles   = 0;
    finished = 1'b0;
    build_expected();
    @(negedge ps_clk);
    readout_start_i = 1'b1;
    @(negedge ps_clk);
    readout_start_i = 1'b0;
    if (beat_valid_o !== 1'b0) begin
      log_failure("beat valid one cycle after readout start");
    end
    @(negedge ps_clk);
    if (beat_valid_o !== 1'b1) begin
      log_failure("no beat two cycles after readout start");
    end
    while (!finished) begin
      r = stall ? rand_bits(1) : 32'h1;
      beat_ready_i = r[0];
      if (beat_valid_o && beat_ready_i) begin
        if (beat_o !== expected[idx]) begin
          log_failure($sformatf("beat %0d is %h, expected %h", idx, beat_o, expected[idx]));
        end
        idx++;
      end
      if (idx == expected.size() || (abort_after > 0 && idx == abort_after)) begin
        finished = 1'b1;
      end else if (cycles == READ_LIMIT) begin
        $display("readout timed out after %0d of %0d beats", idx, expected.size());
        errors++;
        finished = 1'b1;
      end else begin
        cycles++;
        @(negedge ps_clk);
      end
    end
    @(negedge ps_clk);
    beat_ready_i = 1'b0;
    if (abort_after > 0 && idx == abort_after && idx < expected.size()) begin
      readout_reset_i = 1'b1;
      @(negedge ps_clk);
      readout_reset_i = 1'b0;
      if (beat_valid_o !== 1'b0) begin
        log_failure("beat still valid after readout reset");
      end
    end else if (beat_valid_o !== 1'b0) begin
      log_failure("beat valid after the last beat");
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic dual_bank_capture();
    int e0;
    e0 = errors;
    reset_capture(DUAL_BANK);
    pulse_cmd(1'b1, 1'b1, 1'b0, 1'b0);
    send_samples(30, 1'b1);
    pulse_cmd(1'b0, 1'b0, 1'b1, 1'b0);
    check_status(DONE, 30, "dual bank stop");
    read_stream(0, 1'b0);
    finish_test("dual_bank_capture", e0);
  endtask

  task automatic triggered_capture();
    int e0;
    e0 = errors;
    reset_capture(DUAL_BANK);
    pulse_cmd(1'b1, 1'b0, 1'b0, 1'b0);
    check_status(ARMED, 0, "after arm");
    send_samples(8, 1'b0);
    check_status(ARMED, 0, "armed samples dropped");
    pulse_trigger();
    check_status(CAPTURING, 0, "after trigger");
    send_samples(20, 1'b1);
    pulse_cmd(1'b0, 1'b0, 1'b1, 1'b0);
    check_status(DONE, 20, "triggered stop");
    read_stream(0, 1'b0);
    finish_test("triggered_capture", e0);
  endtask

  task automatic single_channel_fill();
    int e0;
    e0 = errors;
    reset_capture(SINGLE_CHANNEL);
    pulse_cmd(1'b1, 1'b1, 1'b0, 1'b0);
    send_samples(140, 1'b1);
    check_status(DONE, N_BANKS * BANK_DEPTH, "single channel full");
    read_stream(0, 1'b0);
    finish_test("single_channel_fill", e0);
  endtask

  task automatic capture_restart();
    int e0;
    e0 = errors;
    reset_capture(DUAL_BANK);
    pulse_cmd(1'b0, 1'b1, 1'b0, 1'b0);
    send_samples(10, 1'b1);
    reset_capture(DUAL_BANK);
    check_status(IDLE, 0, "after capture reset");
    pulse_cmd(1'b1, 1'b1, 1'b0, 1'b0);
    send_samples(15, 1'b1);
    pulse_cmd(1'b0, 1'b0, 1'b1, 1'b0);
    check_status(DONE, 15, "second capture");
    read_stream(0, 1'b0);
    finish_test("capture_restart", e0);
  endtask

  task automatic readout_abort();
    int e0;
    e0 = errors;
    reset_capture(DUAL_BANK);
    pulse_cmd(1'b1, 1'b1, 1'b0, 1'b0);
    send_samples(12, 1'b1);
    pulse_cmd(1'b0, 1'b0, 1'b1, 1'b0);
    read_stream(5, 1'b0);
    read_stream(0, 1'b0);
    finish_test("readout_abort", e0);
  endtask

  task automatic readout_backpressure();
    int e0;
    e0 = errors;
    reset_capture(DUAL_BANK);
    pulse_cmd(1'b1, 1'b1, 1'b0, 1'b0);
    send_samples(BANK_DEPTH, 1'b1);
    check_status(DONE, BANK_DEPTH, "dual bank full");
    read_stream(0, 1'b1);
    finish_test("readout_backpressure", e0);
  endtask

  initial begin
    int assert_failures;
    rst_i           = 1'b1;
    cmd_i           = '0;
    trigger_i       = 1'b0;
    mode_i          = DUAL_BANK;
    model_mode      = DUAL_BANK;
    samples_i       = '0;
    sample_valid_i  = 1'b0;
    readout_start_i = 1'b0;
    readout_reset_i = 1'b0;
    beat_ready_i    = 1'b0;
    repeat (16) @(posedge ps_clk);
    @(negedge ps_clk);
    rst_i = 1'b0;
    check_status(IDLE, 0, "after reset");
    if (beat_valid_o !== 1'b0) begin
      log_failure("beat valid after reset");
    end
    dual_bank_capture();
    triggered_capture();
    single_channel_fill();
    capture_restart();
    readout_abort();
    readout_backpressure();
    assert_failures = i_timetag_buffer.i_timetag_buffer_properties.failure_count;
    $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
             passed, failed, errors, assert_failures);
    if (failed == 0 && errors == 0 && assert_failures == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
source/buffer_cfg_pkg.sv
source/sample_data_pkg.sv
source/capture_fsm.sv
source/write_addr_counter.sv
source/sample_bank.sv
source/readout_sequencer.sv
source/timetag_buffer.sv
tb/timetag_buffer_properties.sv
tb/timetag_buffer_tb.sv

// File: Bender.yml
package:
  name: timetag_buffer

sources:
  - files:
      - source/buffer_cfg_pkg.sv
      - source/sample_data_pkg.sv
      - source/capture_fsm.sv
      - source/write_addr_counter.sv
      - source/sample_bank.sv
      - source/readout_sequencer.sv
      - source/timetag_buffer.sv
  - target: test
    files:
      - tb/timetag_buffer_properties.sv
      - tb/timetag_buffer_tb.sv
